// File: rtl/fp_accum_pkg.sv
package fp_accum_pkg;

    ////////////////////////////////////////////////////////////
    // Field and limb geometry
    ////////////////////////////////////////////////////////////

    // Width of one field element
    localparam int FP_W = 32;
    // Bits per limb
    localparam int LIMB_W = 8;
    // Limbs per polynomial
    localparam int ADD_DIV = FP_W / LIMB_W;
    // Signed carry width of a level-3 limb
    localparam int L3_CW = 4;
    // Carry and value of a level-3 limb together
    localparam int L3_LIMB_W = LIMB_W + L3_CW;

    // Prime 2^32 minus 5
    localparam logic [FP_W-1:0] MOD = 32'hFFFF_FFFB;
    // 2^32 mod p, weight of every folded high bit
    localparam int unsigned FOLD_C = 5;
    // 16 times p, lifts the most negative reachable sum above zero
    localparam logic [FP_W+4:0] NEG_BIAS = {1'b0, MOD, 4'b0000};
    // Signed width of the weighted limb sum
    localparam int RES_W = 40;

    // Register banks of lanes 2 and 3
    localparam int BANK_D = 3;
    localparam int ADDR_W = 2;

    ////////////////////////////////////////////////////////////
    // Limb and polynomial types
    ////////////////////////////////////////////////////////////

    typedef logic [FP_W-1:0] uint_fp_t;

    // Level 1, one carry bit over the limb value
    typedef struct packed {
        logic              carry;
        logic [LIMB_W-1:0] val;
    } limb_l1_t;

    typedef limb_l1_t [ADD_DIV-1:0] redundant_poly_l1;

    // Level 3, signed carry
    // Read as one signed word the limb equals carry*256 + val
    typedef struct packed {
        logic signed [L3_CW-1:0] carry;
        logic [LIMB_W-1:0]       val;
    } limb_l3_t;

    typedef limb_l3_t [ADD_DIV-1:0] redundant_poly_l3;

    ////////////////////////////////////////////////////////////
    // Command word
    ////////////////////////////////////////////////////////////

    // Lane operation on register R with input X
    typedef enum logic [2:0] {
        ACC_HOLD = 3'd0,  // R
        ACC_LOAD = 3'd1,  // X
        ACC_ADD  = 3'd2,  // X + R
        ACC_RSUB = 3'd3,  // X - R
        ACC_SUB  = 3'd4,  // R - X
        ACC_NEG  = 3'd5   // MOD - R
    } acc_mode_t;

    // Register routed to the resolver
    typedef enum logic [1:0] {
        OUT_R1   = 2'd0,
        OUT_R2   = 2'd1,
        OUT_R3   = 2'd2,
        OUT_ZERO = 2'd3
    } out_sel_t;

    typedef struct packed {
        acc_mode_t         mode1;
        acc_mode_t         mode2;
        acc_mode_t         mode3;
        logic [ADDR_W-1:0] addr2;
        logic [ADDR_W-1:0] addr3;
        out_sel_t          outsel;
    } acc_cmd_t;

    // Command seen during reset
    localparam acc_cmd_t CMD_IDLE = '{
        mode1:  ACC_HOLD,
        mode2:  ACC_HOLD,
        mode3:  ACC_HOLD,
        addr2:  '0,
        addr3:  '0,
        outsel: OUT_R1
    };

endpackage

// File: rtl/operand_stage.sv
`timescale 1ns/1ns

module operand_stage (
    input  logic                           clk,
    input  logic                           rstn,
    input  fp_accum_pkg::uint_fp_t         a,
    input  fp_accum_pkg::uint_fp_t         b,
    input  fp_accum_pkg::acc_cmd_t         cmd,
    output fp_accum_pkg::redundant_poly_l1 sum_l1,
    output fp_accum_pkg::acc_cmd_t         cmd_q
);

    import fp_accum_pkg::*;

    ////////////////////////////////////////////////////////////
    // Limb-wise sum
    ////////////////////////////////////////////////////////////

    // Next level-1 polynomial
    redundant_poly_l1 sum_d;

    // Each limb keeps its own ninth bit
    // No carry moves to the next limb
    for (genvar i = 0; i < ADD_DIV; i++) begin : g_limb
        logic [LIMB_W-1:0] a_limb;
        logic [LIMB_W-1:0] b_limb;

        assign a_limb = a[i*LIMB_W +: LIMB_W];
        assign b_limb = b[i*LIMB_W +: LIMB_W];

        // 9-bit result fills carry and value of the limb
        assign sum_d[i] = {1'b0, a_limb} + {1'b0, b_limb};
    end

    ////////////////////////////////////////////////////////////
    // Capture registers
    ////////////////////////////////////////////////////////////

    // Sum and command move together
    // Both reach the postadder on the same edge
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sum_l1 <= '0;
            // Hold all lanes, route reg1
            cmd_q  <= CMD_IDLE;
        end else begin
            sum_l1 <= sum_d;
            cmd_q  <= cmd;
        end
    end

endmodule

// File: rtl/poly_adder_l3.sv
`timescale 1ns/1ns

module poly_adder_l3 (
    input  logic                           sub,
    input  fp_accum_pkg::redundant_poly_l3 x,
    input  fp_accum_pkg::redundant_poly_l3 y,
    output fp_accum_pkg::redundant_poly_l3 z
);

    import fp_accum_pkg::*;

    ////////////////////////////////////////////////////////////
    // Carry-free limb arithmetic
    ////////////////////////////////////////////////////////////

    // Limbs stay independent
    // Value of z is exact while every limb carry fits in L3_CW bits
    for (genvar i = 0; i < ADD_DIV; i++) begin : g_limb
        // Signed limb values
        logic signed [L3_LIMB_W-1:0] x_val;
        logic signed [L3_LIMB_W-1:0] y_val;
        logic signed [L3_LIMB_W-1:0] z_val;

        // Carry over value read as one signed word
        assign x_val = $signed(x[i]);
        assign y_val = $signed(y[i]);

        // Wraps only when the caller overruns the carry range
        assign z_val = sub ? (x_val - y_val) : (x_val + y_val);

        // Low byte to val, upper signed bits to carry
        assign z[i] = z_val;
    end

endmodule

// File: rtl/postadder.sv
`timescale 1ns/1ns

module postadder (
    input  logic                           clk,
    input  logic                           rstn,
    input  fp_accum_pkg::redundant_poly_l1 in_l1,
    input  fp_accum_pkg::acc_cmd_t         cmd,
    output fp_accum_pkg::redundant_poly_l3 dout
);

    import fp_accum_pkg::*;

    // Operands and mode of one lane adder
    typedef struct packed {
        logic             sub;
        redundant_poly_l3 x;
        redundant_poly_l3 y;
    } lane_op_t;

    ////////////////////////////////////////////////////////////
    // Format conversion
    ////////////////////////////////////////////////////////////

    // Level 1 to level 3, carry zero-extended
    function automatic redundant_poly_l3 l1_to_l3(input redundant_poly_l1 p);
        redundant_poly_l3 q;
        for (int i = 0; i < ADD_DIV; i++) begin
            q[i].carry = L3_CW'(p[i].carry);
            q[i].val   = p[i].val;
        end
        return q;
    endfunction

    // Canonical integer in limb form with zero carries
    function automatic redundant_poly_l3 int_to_l3(input uint_fp_t v);
        redundant_poly_l3 q;
        for (int i = 0; i < ADD_DIV; i++) begin
            q[i].carry = '0;
            q[i].val   = v[i*LIMB_W +: LIMB_W];
        end
        return q;
    endfunction

    // Mode to adder operands
    // Default leaves 0 + R, which also covers HOLD and reserved codes
    function automatic lane_op_t decode_lane(
        input acc_mode_t        mode,
        input redundant_poly_l3 din,
        input redundant_poly_l3 r
    );
        lane_op_t op;
        op.sub = 1'b0;
        op.x   = '0;
        op.y   = r;
        case (mode)
            ACC_LOAD: begin
                op.y = din;
            end
            ACC_ADD: begin
                op.x = din;
            end
            ACC_RSUB: begin
                op.x   = din;
                op.sub = 1'b1;
            end
            ACC_SUB: begin
                op.x   = r;
                op.y   = din;
                op.sub = 1'b1;
            end
            ACC_NEG: begin
                op.x   = int_to_l3(MOD);
                op.sub = 1'b1;
            end
            default: begin
                op.sub = 1'b0;
            end
        endcase
        return op;
    endfunction

    ////////////////////////////////////////////////////////////
    // Lane registers
    ////////////////////////////////////////////////////////////

    redundant_poly_l3 in_l3;
    redundant_poly_l3 reg1;
    redundant_poly_l3 reg2 [BANK_D];
    redundant_poly_l3 reg3 [BANK_D];

    // Bank entries addressed by this command
    redundant_poly_l3 reg2_rd;
    redundant_poly_l3 reg3_rd;

    assign in_l3   = l1_to_l3(in_l1);
    assign reg2_rd = reg2[cmd.addr2];
    assign reg3_rd = reg3[cmd.addr3];

    ////////////////////////////////////////////////////////////
    // Lane adders
    ////////////////////////////////////////////////////////////

    lane_op_t         op1, op2, op3;
    redundant_poly_l3 acc1_out, acc2_out, acc3_out;

    assign op1 = decode_lane(cmd.mode1, in_l3, reg1);
    assign op2 = decode_lane(cmd.mode2, in_l3, reg2_rd);
    assign op3 = decode_lane(cmd.mode3, in_l3, reg3_rd);

    poly_adder_l3 acc1 (.sub(op1.sub), .x(op1.x), .y(op1.y), .z(acc1_out));
    poly_adder_l3 acc2 (.sub(op2.sub), .x(op2.x), .y(op2.y), .z(acc2_out));
    poly_adder_l3 acc3 (.sub(op3.sub), .x(op3.x), .y(op3.y), .z(acc3_out));

    // Output selection, old register contents
    redundant_poly_l3 dout_d;

    always_comb begin
        case (cmd.outsel)
            OUT_R1:  dout_d = reg1;
            OUT_R2:  dout_d = reg2_rd;
            OUT_R3:  dout_d = reg3_rd;
            default: dout_d = '0;
        endcase
    end

    // Write-back and output on the same edge
    // dout sees the value from before this write
    always_ff @(posedge clk) begin
        if (!rstn) begin
            reg1 <= '0;
            for (int i = 0; i < BANK_D; i++) begin
                reg2[i] <= '0;
                reg3[i] <= '0;
            end
            dout <= '0;
        end else begin
            reg1            <= acc1_out;
            reg2[cmd.addr2] <= acc2_out;
            reg3[cmd.addr3] <= acc3_out;
            dout            <= dout_d;
        end
    end

endmodule

// File: rtl/carry_resolver.sv
`timescale 1ns/1ns

module carry_resolver (
    input  logic                           clk,
    input  logic                           rstn,
    input  fp_accum_pkg::redundant_poly_l3 din,
    output fp_accum_pkg::uint_fp_t         result
);

    import fp_accum_pkg::*;

    // Weighted sum of signed limbs
    function automatic logic signed [RES_W-1:0] poly_value(input redundant_poly_l3 p);
        logic signed [RES_W-1:0] acc;
        logic signed [RES_W-1:0] limb;
        acc = '0;
        for (int i = 0; i < ADD_DIV; i++) begin
            // Sign extension from the 12-bit limb word
            limb = $signed(p[i]);
            acc  = acc + (limb <<< (LIMB_W * i));
        end
        return acc;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stage 1, limb sum
    ////////////////////////////////////////////////////////////

    logic signed [RES_W-1:0] sum_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sum_q <= '0;
        end else begin
            sum_q <= poly_value(din);
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2, bias and first fold
    ////////////////////////////////////////////////////////////

    // Non-negative after the bias, below 2^37
    logic [RES_W-1:0] biased;
    logic [FP_W:0]    fold1_d;
    logic [FP_W:0]    fold1_q;

    assign biased = sum_q + RES_W'(NEG_BIAS);
    // High bits weigh 2^32, which is 5 mod p
    assign fold1_d = biased[FP_W-1:0] + FOLD_C * biased[RES_W-1:FP_W];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fold1_q <= '0;
        end else begin
            fold1_q <= fold1_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 3, second fold and final correction
    ////////////////////////////////////////////////////////////

    // At most one high bit left
    logic [FP_W:0] fold2;
    logic [FP_W:0] corr1;
    logic [FP_W:0] corr2;

    assign fold2 = fold1_q[FP_W-1:0] + FOLD_C * fold1_q[FP_W];

    // Up to two conditional subtractions of p
    assign corr1 = (fold2 >= MOD) ? (fold2 - MOD) : fold2;
    assign corr2 = (corr1 >= MOD) ? (corr1 - MOD) : corr1;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            result <= '0;
        end else begin
            // Canonical residue, top bit is zero here
            result <= corr2[FP_W-1:0];
        end
    end

endmodule

// File: rtl/fp_accum_top.sv
`timescale 1ns/1ns

module fp_accum_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  fp_accum_pkg::uint_fp_t a,
    input  fp_accum_pkg::uint_fp_t b,
    input  fp_accum_pkg::acc_cmd_t cmd,
    output fp_accum_pkg::uint_fp_t result
);

    import fp_accum_pkg::*;

    ////////////////////////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////////////////////////

    // Operand stage to postadder
    redundant_poly_l1 sum_l1;
    acc_cmd_t         cmd_q;

    // Postadder to resolver
    redundant_poly_l3 dout;

    // Capture at E0
    operand_stage u_operand_stage (
        .clk    (clk),
        .rstn   (rstn),
        .a      (a),
        .b      (b),
        .cmd    (cmd),
        .sum_l1 (sum_l1),
        .cmd_q  (cmd_q)
    );

    // Lane write-back and selection at E1
    postadder u_postadder (
        .clk   (clk),
        .rstn  (rstn),
        .in_l1 (sum_l1),
        .cmd   (cmd_q),
        .dout  (dout)
    );

    // Canonical result after E4
    carry_resolver u_carry_resolver (
        .clk    (clk),
        .rstn   (rstn),
        .din    (dout),
        .result (result)
    );

endmodule

// File: testbench/fp_accum_chk.sv
`timescale 1ns/1ns

module fp_accum_chk (
    input logic                   clk,
    input logic                   rstn,
    input fp_accum_pkg::uint_fp_t a,
    input fp_accum_pkg::uint_fp_t b,
    input fp_accum_pkg::acc_cmd_t cmd,
    input fp_accum_pkg::uint_fp_t result
);

    import fp_accum_pkg::*;

    // Failed assertions and compared results
    int unsigned fail_cnt = 0;
    int unsigned checked_cnt;

    // (x + y) mod p for any two 32-bit words
    function automatic uint_fp_t mod_sum(input uint_fp_t x, input uint_fp_t y);
        logic [FP_W:0] s;
        s = {1'b0, x} + {1'b0, y};
        return uint_fp_t'(s % {1'b0, MOD});
    endfunction

    // Lane rule on residues, input x and register r
    function automatic uint_fp_t lane_step(
        input acc_mode_t m,
        input uint_fp_t  x,
        input uint_fp_t  r
    );
        case (m)
            ACC_LOAD: return x;
            ACC_ADD:  return mod_sum(x, r);
            ACC_RSUB: return mod_sum(x, MOD - r);
            ACC_SUB:  return mod_sum(r, MOD - x);
            ACC_NEG:  return mod_sum(MOD - r, '0);
            default:  return r;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Shadow registers
    ////////////////////////////////////////////////////////////

    uint_fp_t   x_q;
    acc_cmd_t   cmd_q;
    uint_fp_t   sh1;
    uint_fp_t   sh2 [BANK_D];
    uint_fp_t   sh3 [BANK_D];
    uint_fp_t   sel_d;
    // Expected result, one slot per cycle after the lane write
    uint_fp_t   exp_q [4];
    // Capture marks, bit 4 lines up with result
    logic [4:0] vld;

    // Old register contents, as the postadder reads them
    always_comb begin
        case (cmd_q.outsel)
            OUT_R1:  sel_d = sh1;
            OUT_R2:  sel_d = sh2[cmd_q.addr2];
            OUT_R3:  sel_d = sh3[cmd_q.addr3];
            default: sel_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            x_q   <= '0;
            cmd_q <= CMD_IDLE;
            sh1   <= '0;
            for (int i = 0; i < BANK_D; i++) begin
                sh2[i] <= '0;
                sh3[i] <= '0;
            end
            for (int i = 0; i < 4; i++) begin
                exp_q[i] <= '0;
            end
            vld         <= '0;
            checked_cnt <= 0;
        end else begin
            // Capture edge E0
            x_q   <= mod_sum(a, b);
            cmd_q <= cmd;
            // Lane writes at E1
            sh1              <= lane_step(cmd_q.mode1, x_q, sh1);
            sh2[cmd_q.addr2] <= lane_step(cmd_q.mode2, x_q, sh2[cmd_q.addr2]);
            sh3[cmd_q.addr3] <= lane_step(cmd_q.mode3, x_q, sh3[cmd_q.addr3]);
            exp_q[0] <= sel_d;
            for (int i = 1; i < 4; i++) begin
                exp_q[i] <= exp_q[i-1];
            end
            vld <= {vld[3:0], 1'b1};
            if (vld[4]) begin
                checked_cnt <= checked_cnt + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////

    // Result equals the shadow register chosen four cycles after capture
    a_result_match: assert property (@(posedge clk) disable iff (!rstn)
        vld[4] |-> result == exp_q[3])
        else begin
            $error("ERROR at %0t: result %h, expected %h",
                   $time, $sampled(result), $sampled(exp_q[3]));
            fail_cnt++;
        end

    // OUT_ZERO reaches the output as zero
    a_zero_sel: assert property (@(posedge clk) disable iff (!rstn)
        cmd.outsel == OUT_ZERO |-> ##5 result == '0)
        else begin
            $error("ERROR at %0t: result %h after OUT_ZERO", $time, $sampled(result));
            fail_cnt++;
        end

    a_reset_clear: assert property (@(posedge clk) !rstn |=> result == '0)
        else begin
            $error("ERROR at %0t: result %h not cleared by reset", $time, $sampled(result));
            fail_cnt++;
        end

endmodule

bind fp_accum_top fp_accum_chk u_chk (
    .clk    (clk),
    .rstn   (rstn),
    .a      (a),
    .b      (b),
    .cmd    (cmd),
    .result (result)
);

// File: testbench/tb_fp_accum.sv
`timescale 1ns/1ns

module tb_fp_accum;

    import fp_accum_pkg::*;

    localparam logic [31:0] SEED = 32'h7f3e;
    // Galois taps for x^32 + x^30 + x^26 + x^25 + 1
    localparam logic [31:0] TAPS = 32'hA300_0000;
    // Idle cycles allowed for the last results
    localparam int DRAIN_MAX = 20;

    logic        clk = 1'b0;
    logic        rstn;
    uint_fp_t    a;
    uint_fp_t    b;
    acc_cmd_t    cmd;
    uint_fp_t    result;
    logic [31:0] lfsr = SEED;
    int          n_issued;
    int          target;
    int          cyc;
    int          i;

    fp_accum_top UUT (
        .clk    (clk),
        .rstn   (rstn),
        .a      (a),
        .b      (b),
        .cmd    (cmd),
        .result (result)
    );

    // 100 ns period
    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ TAPS;
        end
        return n;
    endfunction

    // One LFSR step per bit, LSB first
    task automatic draw_word(output uint_fp_t w);
        w = '0;
        for (int k = 0; k < FP_W; k++) begin
            w    = {lfsr[0], w[FP_W-1:1]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic acc_cmd_t make_cmd(
        input acc_mode_t  m1,
        input acc_mode_t  m2,
        input acc_mode_t  m3,
        input logic [1:0] ad2,
        input logic [1:0] ad3,
        input out_sel_t   sel
    );
        acc_cmd_t c;
        c.mode1  = m1;
        c.mode2  = m2;
        c.mode3  = m3;
        c.addr2  = ad2;
        c.addr3  = ad3;
        c.outsel = sel;
        return c;
    endfunction

    task automatic report_failure(input string why);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", why);
    endtask

    // New inputs on the falling edge, one command per cycle
    task automatic drive_cmd(input acc_cmd_t c, input uint_fp_t x, input uint_fp_t y);
        @(negedge clk);
        a   = x;
        b   = y;
        cmd = c;
        n_issued++;
    endtask

    task automatic issue_random(input acc_cmd_t c);
        uint_fp_t x;
        uint_fp_t y;
        draw_word(x);
        draw_word(y);
        drive_cmd(c, x, y);
    endtask

    always @(negedge clk) begin
        if (UUT.u_chk.fail_cnt != 0) begin
            report_failure("assertion failure in the bound checker");
        end
    end

    initial begin
        rstn     = 1'b0;
        a        = '0;
        b        = '0;
        cmd      = CMD_IDLE;
        n_issued = 0;
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
        end
        // Release cycle captures the idle command
        rstn     = 1'b1;
        n_issued = 1;
        issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'd0, 2'd0, OUT_R1));

        // Loads into reg1 and every bank entry
        for (i = 0; i < BANK_D; i++) begin
            issue_random(make_cmd(ACC_LOAD, ACC_LOAD, ACC_HOLD, 2'(i), 2'd0, OUT_R1));
        end
        for (i = 0; i < BANK_D; i++) begin
            issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_LOAD, 2'd0, 2'(i), OUT_R1));
        end
        // Back-to-back reads of all entries
        for (i = 0; i < BANK_D; i++) begin
            issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'(i), 2'(i), OUT_R2));
            issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'(i), 2'(i), OUT_R3));
            issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'(i), 2'(i), OUT_R1));
        end

        // Chains of three, each step reads the previous one
        issue_random(make_cmd(ACC_ADD,  ACC_ADD,  ACC_SUB,  2'd1, 2'd2, OUT_R1));
        issue_random(make_cmd(ACC_SUB,  ACC_RSUB, ACC_ADD,  2'd1, 2'd2, OUT_R2));
        issue_random(make_cmd(ACC_RSUB, ACC_SUB,  ACC_RSUB, 2'd1, 2'd2, OUT_R3));
        issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'd1, 2'd2, OUT_R1));
        issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'd1, 2'd2, OUT_R2));
        issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'd1, 2'd2, OUT_R3));

        // Negative true values, 1 - X in reg1 and reg2
        drive_cmd(make_cmd(ACC_LOAD, ACC_LOAD, ACC_HOLD, 2'd0, 2'd0, OUT_R1), 32'd1, '0);
        issue_random(make_cmd(ACC_SUB, ACC_SUB, ACC_HOLD, 2'd0, 2'd0, OUT_R1));
        issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'd0, 2'd0, OUT_R1));
        issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'd0, 2'd0, OUT_R2));

        // NEG twice returns the loaded value
        issue_random(make_cmd(ACC_LOAD, ACC_HOLD, ACC_HOLD, 2'd0, 2'd0, OUT_R1));
        issue_random(make_cmd(ACC_NEG,  ACC_HOLD, ACC_HOLD, 2'd0, 2'd0, OUT_R1));
        issue_random(make_cmd(ACC_NEG,  ACC_HOLD, ACC_HOLD, 2'd0, 2'd0, OUT_R1));
        issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'd0, 2'd0, OUT_R1));
        // NEG of zero, and p itself loaded
        drive_cmd(make_cmd(ACC_LOAD, ACC_HOLD, ACC_LOAD, 2'd0, 2'd0, OUT_R1), MOD, '0);
        issue_random(make_cmd(ACC_NEG,  ACC_HOLD, ACC_NEG,  2'd0, 2'd0, OUT_R1));
        issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'd0, 2'd0, OUT_R3));
        issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'd0, 2'd0, OUT_R1));

        // Independent banks, then every entry read again
        issue_random(make_cmd(ACC_HOLD, ACC_LOAD, ACC_LOAD, 2'd2, 2'd1, OUT_ZERO));
        for (i = 0; i < BANK_D; i++) begin
            issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'(i), 2'(i), OUT_R2));
            issue_random(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'(i), 2'(i), OUT_R3));
        end

        // Idle until every captured command has been compared
        target = n_issued;
        cyc    = 0;
        while (UUT.u_chk.checked_cnt < target && cyc < DRAIN_MAX) begin
            drive_cmd(make_cmd(ACC_HOLD, ACC_HOLD, ACC_HOLD, 2'd0, 2'd0, OUT_ZERO), '0, '0);
            cyc++;
        end
        if (UUT.u_chk.checked_cnt < target) begin
            report_failure("timeout while waiting for the last results");
        end else if (UUT.u_chk.fail_cnt != 0) begin
            report_failure("assertion failure in the bound checker");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: sources.f
rtl/fp_accum_pkg.sv
rtl/operand_stage.sv
rtl/poly_adder_l3.sv
rtl/postadder.sv
rtl/carry_resolver.sv
rtl/fp_accum_top.sv
testbench/fp_accum_chk.sv
testbench/tb_fp_accum.sv
